// File: rv_exec_top.f
source/rv_exec_pkg.sv
source/rv_alu.sv
source/rv_decode.sv
source/rv_execute.sv
source/rv_result.sv
source/rv_exec_top.sv
tb/rv_exec_tb.sv

// File: Bender.yml
package:
  name: rv_exec

sources:
  - source/rv_exec_pkg.sv
  - source/rv_alu.sv
  - source/rv_decode.sv
  - source/rv_execute.sv
  - source/rv_result.sv
  - source/rv_exec_top.sv
  - target: simulation
    files:
      - tb/rv_exec_tb.sv

// File: tb/rv_exec_tb.sv
`timescale 1ns/100ps

module rv_exec_tb import rv_exec_pkg::*; ();

    localparam xlen_t PROG_BASE = 32'h0000_0400;

    logic    clk;
    logic    rst;
    logic    inst_valid;
    logic    inst_ready;
    xlen_t   inst;
    xlen_t   pc;
    logic    retire_valid;
    retire_t retire;
    logic    retire_ready;
    logic    redirect_valid;
    xlen_t   redirect_pc;
    logic    redirect_ack;

    xlen_t       prog [64];
    int          prog_len;
    xlen_t       model_rf [32];
    retire_t     exp_retire [$];
    bit          exp_full [$];   // rd and wdata are meaningful.
    xlen_t       exp_redirect [$];
    xlen_t       fetch_pc;
    bit          acked;
    int unsigned lcg_state = 90989;

    rv_exec_top #(
        .BYPASS_DEPTH (4)
    ) rv_exec_top_i (
        .clk            (clk),
        .rst            (rst),
        .inst_valid     (inst_valid),
        .inst_ready     (inst_ready),
        .inst           (inst),
        .pc             (pc),
        .retire_valid   (retire_valid),
        .retire         (retire),
        .retire_ready   (retire_ready),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .redirect_ack   (redirect_ack)
    );

    initial clk = 1'b0;
    always #2 clk = ~clk;

    function automatic int unsigned lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state >> 8;
    endfunction

    function automatic reg_addr_t random_reg(input int unsigned lo, input int unsigned span);
        return reg_addr_t'(lo + lcg_next() % span);
    endfunction

    function automatic xlen_t r_type(input logic [6:0] f7, input reg_addr_t rs2,
                                     input reg_addr_t rs1, input logic [2:0] f3,
                                     input reg_addr_t rd, input logic [6:0] opc);
        return {f7, rs2, rs1, f3, rd, opc};
    endfunction

    function automatic xlen_t i_type(input logic [11:0] imm, input reg_addr_t rs1,
                                     input logic [2:0] f3, input reg_addr_t rd,
                                     input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic xlen_t u_type(input logic [19:0] imm, input reg_addr_t rd,
                                     input logic [6:0] opc);
        return {imm, rd, opc};
    endfunction

    function automatic xlen_t b_type(input logic [12:0] off, input reg_addr_t rs2,
                                     input reg_addr_t rs1, input logic [2:0] f3);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OPC_BRANCH};
    endfunction

    function automatic xlen_t j_type(input logic [20:0] off, input reg_addr_t rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, OPC_JAL};
    endfunction

    function automatic xlen_t random_alu(input reg_addr_t rd, input reg_addr_t rs1,
                                         input reg_addr_t rs2);
        logic [2:0]  f3;
        logic [11:0] imm;
        logic        alt;
        f3  = 3'(lcg_next());
        imm = 12'(lcg_next());
        alt = lcg_next() % 2 == 1;
        case (lcg_next() % 4)
            0: begin
                if (f3 == 3'b001) imm = {7'b0, imm[4:0]};
                if (f3 == 3'b101) imm = {1'b0, alt, 5'b0, imm[4:0]};
                return i_type(imm, rs1, f3, rd, OPC_OP_IMM);
            end
            1: return r_type(((f3 == 3'b000) || (f3 == 3'b101)) && alt ? 7'h20 : 7'h00,
                             rs2, rs1, f3, rd, OPC_OP);
            2: return u_type(20'(lcg_next()), rd, OPC_LUI);
            default: return u_type(20'(lcg_next()), rd, OPC_AUIPC);
        endcase
    endfunction

    function automatic xlen_t alu_model(input logic [2:0] f3, input logic alt,
                                        input xlen_t x, input xlen_t y);
        case (f3)
            3'b000: return alt ? x - y : x + y;
            3'b001: return x << y[4:0];
            3'b010: return ($signed(x) < $signed(y)) ? 32'd1 : 32'd0;
            3'b011: return (x < y) ? 32'd1 : 32'd0;
            3'b100: return x ^ y;
            3'b101: begin
                if (alt) return $signed(x) >>> y[4:0]; // arithmetic form.
                else return x >> y[4:0];
            end
            3'b110: return x | y;
            default: return x & y;
        endcase
    endfunction

    function automatic logic branch_taken(input logic [2:0] f3, input xlen_t x, input xlen_t y);
        case (f3)
            3'b000: return x == y;
            3'b001: return x != y;
            3'b100: return $signed(x) < $signed(y);
            3'b101: return $signed(x) >= $signed(y);
            3'b110: return x < y;
            3'b111: return x >= y;
            default: return 1'b0;
        endcase
    endfunction

    function automatic bit in_program(input xlen_t addr);
        return (addr >= PROG_BASE) && (addr < PROG_BASE + 4 * prog_len);
    endfunction

    task automatic emit(input xlen_t ins);
        prog[prog_len] = ins;
        prog_len++;
    endtask

    // architectural step of one instruction.
    task automatic model_step(input xlen_t ins, inout xlen_t mpc);
        logic [2:0] f3;
        logic [6:0] f7;
        reg_addr_t  rd;
        xlen_t      a;
        xlen_t      b;
        xlen_t      imm_i;
        xlen_t      next;
        xlen_t      val;
        logic       wr;
        logic       ill;
        logic       full;
        retire_t    rec;
        f3    = ins[14:12];
        f7    = ins[31:25];
        rd    = ins[11:7];
        a     = model_rf[ins[19:15]];
        b     = model_rf[ins[24:20]];
        imm_i = {{20{ins[31]}}, ins[31:20]};
        next  = mpc + 4;
        val   = '0;
        wr    = 1'b1;
        ill   = 1'b0;
        full  = 1'b1;
        case (ins[6:0])
            OPC_LUI:   val = {ins[31:12], 12'h000};
            OPC_AUIPC: val = mpc + {ins[31:12], 12'h000};
            OPC_JAL: begin
                val  = mpc + 4;
                next = mpc + {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
            end
            OPC_JALR: begin
                ill  = (f3 != 3'b000);
                val  = mpc + 4;
                next = (a + imm_i) & ~32'd1;
            end
            OPC_BRANCH: begin
                wr   = 1'b0;
                full = 1'b0;
                ill  = (f3[2:1] == 2'b01);
                if (branch_taken(f3, a, b)) begin
                    next = mpc + {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
                end
            end
            OPC_OP_IMM: begin
                ill = ((f3 == 3'b001) && (f7 != 7'h00)) ||
                      ((f3 == 3'b101) && (f7 != 7'h00) && (f7 != 7'h20));
                val = alu_model(f3, (f3 == 3'b101) && f7[5], a, imm_i);
            end
            OPC_OP: begin
                ill = (f7 == 7'h20) ? ((f3 != 3'b000) && (f3 != 3'b101)) : (f7 != 7'h00);
                val = alu_model(f3, f7[5], a, b);
            end
            default: ill = 1'b1;
        endcase
        if (ill) begin
            wr   = 1'b0;
            full = 1'b0;
            next = mpc + 4;
        end
        rec.pc      = mpc;
        rec.rd      = rd;
        rec.wdata   = val;
        rec.we      = wr && (rd != '0);
        rec.illegal = ill;
        exp_retire.push_back(rec);
        exp_full.push_back(full);
        if (rec.we) model_rf[rd] = val;
        if (next != mpc + 4) exp_redirect.push_back(next);
        mpc = next;
    endtask

    task automatic fail_now(input string msg);
        $display("%s", msg);
        $display("Regression failed");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_retire(input retire_t got);
        retire_t exp;
        bit      full;
        if (exp_retire.size() == 0) begin
            fail_now($sformatf("instruction at pc %h retired but none was expected", got.pc));
        end else begin
            exp  = exp_retire.pop_front();
            full = exp_full.pop_front();
            if ((got.pc !== exp.pc) || (got.we !== exp.we) || (got.illegal !== exp.illegal) ||
                (full && ((got.rd !== exp.rd) || (got.wdata !== exp.wdata)))) begin
                fail_now({$sformatf("FAIL at %0t: retire pc %h rd %0d wdata %h we %b ill %b,",
                                    $time, got.pc, got.rd, got.wdata, got.we, got.illegal),
                          $sformatf(" expected pc %h rd %0d wdata %h we %b ill %b",
                                    exp.pc, exp.rd, exp.wdata, exp.we, exp.illegal)});
            end
        end
    endtask

    task automatic check_redirect(input xlen_t got);
        if (exp_redirect.size() == 0) begin
            fail_now($sformatf("redirect to %h raised but no redirect was expected", got));
        end else if (got !== exp_redirect[0]) begin
            fail_now($sformatf("FAIL at %0t: redirect_pc %h, expected %h",
                               $time, got, exp_redirect[0]));
        end else begin
            void'(exp_redirect.pop_front());
        end
    endtask

    // inst_ready follows retire_ready.
    task automatic check_ready(input logic got);
        if (got !== retire_ready) begin
            fail_now($sformatf("FAIL at %0t: inst_ready %b, expected %b",
                               $time, got, retire_ready));
        end
    endtask

    // one cycle of fetch, stall and retire handling.
    task automatic drive_cycle(input bit stall);
        @(negedge clk);
        check_ready(inst_ready);
        if (inst_valid && retire_ready) fetch_pc = fetch_pc + 4; // accepted at last edge.
        redirect_ack = 1'b0;
        if (redirect_valid && !acked) begin
            check_redirect(redirect_pc);
            fetch_pc     = redirect_pc;
            redirect_ack = 1'b1;
            acked        = 1'b1;
        end else if (!redirect_valid) begin
            acked = 1'b0;
        end
        retire_ready = stall ? (lcg_next() % 3 != 0) : 1'b1;
        inst_valid   = !redirect_valid && in_program(fetch_pc);
        if (inst_valid) begin
            inst = prog[(fetch_pc - PROG_BASE) >> 2];
            pc   = fetch_pc;
        end
        if (retire_valid && retire_ready) check_retire(retire); // taken at next edge.
    endtask

    task automatic run_program(input bit stall);
        xlen_t mpc;
        int    cycles;
        mpc    = PROG_BASE;
        cycles = 0;
        while (in_program(mpc) && (cycles < 1000)) begin
            model_step(prog[(mpc - PROG_BASE) >> 2], mpc);
            cycles++;
        end
        fetch_pc = PROG_BASE;
        cycles   = 0;
        while ((exp_retire.size() != 0) || (exp_redirect.size() != 0) || redirect_valid) begin
            drive_cycle(stall);
            cycles++;
            if (cycles > 4000) fail_now("timeout: program did not retire within 4000 cycles");
        end
        for (int i = 0; i < 6; i++) drive_cycle(1'b0); // stray retires show up here.
    endtask

    task automatic reset_and_first_retire();
        if ((retire_valid !== 1'b0) || (redirect_valid !== 1'b0)) begin
            fail_now("retire_valid or redirect_valid is not low after reset");
        end
        prog_len = 0;
        emit(i_type(12'd5, 0, 3'b000, 1, OPC_OP_IMM));
        run_program(1'b0);
    endtask

    task automatic random_alu_ops();
        reg_addr_t rd;
        prog_len = 0;
        for (int r = 1; r < 8; r++) emit(i_type(12'(lcg_next()), 0, 3'b000, 5'(r), OPC_OP_IMM));
        for (int i = 0; i < 30; i++) begin
            rd = (lcg_next() % 6 == 0) ? 5'd0 : 5'(8 + i % 8);
            emit(random_alu(rd, random_reg(1, 7), random_reg(1, 7)));
        end
        run_program(1'b0);
    endtask

    task automatic dependent_chains();
        prog_len = 0;
        for (int d = 1; d <= 5; d++) begin
            for (int k = 0; k < 3; k++) begin
                emit(i_type(12'(lcg_next()), 20, 3'b000, 20, OPC_OP_IMM));
                for (int j = 1; j < d; j++) begin
                    emit(i_type(12'(lcg_next()), 1, 3'b100, 5'(23 + j), OPC_OP_IMM));
                end
            end
            emit(r_type(7'h00, 20, 20, 3'b000, 21, OPC_OP)); // both ports at distance d.
        end
        run_program(1'b0);
    endtask

    task automatic control_flow(input bit stall);
        prog_len = 0;
        emit(i_type(12'd7, 0, 3'b000, 5, OPC_OP_IMM));
        emit(i_type(12'd7, 0, 3'b000, 6, OPC_OP_IMM));
        emit(b_type(13'd8, 6, 5, BR_EQ));               // taken.
        emit(i_type(12'd1, 0, 3'b000, 7, OPC_OP_IMM));
        emit(b_type(13'd8, 6, 5, BR_NE));               // not taken.
        emit(j_type(21'd8, 1));
        emit(i_type(12'd2, 0, 3'b000, 7, OPC_OP_IMM));
        emit(u_type(20'd0, 9, OPC_AUIPC));
        emit(i_type(12'd13, 9, 3'b000, 10, OPC_JALR));  // odd offset, bit 0 dropped.
        emit(i_type(12'd3, 0, 3'b000, 7, OPC_OP_IMM));
        emit(b_type(13'd8, 5, 0, BR_LT));
        emit(i_type(12'd4, 0, 3'b000, 7, OPC_OP_IMM));
        emit(b_type(13'd4, 6, 5, BR_GEU));              // taken onto pc+4.
        emit(b_type(13'd8, 5, 6, BR_LTU));
        emit(i_type(12'd3, 0, 3'b000, 12, OPC_OP_IMM));
        emit(i_type(12'hfff, 12, 3'b000, 12, OPC_OP_IMM));
        emit(b_type(13'h1ffc, 0, 12, BR_NE));           // backward loop.
        emit(b_type(13'd8, 5, 12, BR_GE));
        emit(r_type(7'h00, 10, 1, 3'b000, 11, OPC_OP));
        emit(j_type(21'd8, 0));                         // leaves the program.
        emit(i_type(12'd5, 0, 3'b000, 7, OPC_OP_IMM));
        run_program(stall);
    endtask

    task automatic stall_stream();
        logic [2:0] f3;
        prog_len = 0;
        for (int i = 0; i < 40; i++) begin
            f3 = 3'(lcg_next());
            if (f3[2:1] == 2'b01) f3[2] = 1'b1;
            if (i % 7 == 6) begin
                emit(b_type(13'd8, random_reg(1, 15), random_reg(1, 15), f3));
            end else if (i % 13 == 12) begin
                emit(j_type(21'd8, random_reg(1, 15)));
            end else begin
                emit(random_alu(random_reg(1, 15), random_reg(1, 15), random_reg(1, 15)));
            end
        end
        run_program(1'b1);
    endtask

    task automatic illegal_encoding();
        prog_len = 0;
        emit(i_type(12'd55, 0, 3'b000, 13, OPC_OP_IMM));
        emit(r_type(7'h01, 2, 1, 3'b000, 13, OPC_OP));   // mul, no such unit.
        emit(i_type(12'd0, 13, 3'b010, 13, 7'b0000011)); // lw, no memory unit.
        emit(r_type(7'h00, 0, 13, 3'b000, 14, OPC_OP));
        run_program(1'b0);
    endtask

    initial begin
        rst          = 1'b1;
        inst_valid   = 1'b0;
        inst         = '0;
        pc           = '0;
        retire_ready = 1'b0;
        redirect_ack = 1'b0;
        fetch_pc     = PROG_BASE;
        acked        = 1'b0;
        prog_len     = 0;
        for (int r = 0; r < 32; r++) model_rf[r] = '0;
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        reset_and_first_retire();
        random_alu_ops();
        dependent_chains();
        control_flow(1'b0);
        stall_stream();
        control_flow(1'b1);
        illegal_encoding();
        $display("Regression passed");
        $finish;
    end

endmodule

// File: source/rv_exec_top.sv
`timescale 1ns/100ps

module rv_exec_top import rv_exec_pkg::*; #(
    parameter int BYPASS_DEPTH = 4
) (
    input  logic    clk,
    input  logic    rst,
    input  logic    inst_valid,
    output logic    inst_ready,
    input  xlen_t   inst,
    input  xlen_t   pc,
    output logic    retire_valid,
    output retire_t retire,
    input  logic    retire_ready,
    output logic    redirect_valid,
    output xlen_t   redirect_pc,
    input  logic    redirect_ack
);

    logic      advance;
    reg_addr_t rf_rs1;
    reg_addr_t rf_rs2;
    xlen_t     rf_rs1_data;
    xlen_t     rf_rs2_data;
    decoded_t  dec;
    executed_t exe;

    assign advance    = retire_ready; // one global stall.
    assign inst_ready = retire_ready;

    rv_decode decode_i (
        .clk         (clk),
        .rst         (rst),
        .advance     (advance),
        .inst_valid  (inst_valid),
        .inst        (inst),
        .pc          (pc),
        .rf_rs1      (rf_rs1),
        .rf_rs2      (rf_rs2),
        .rf_rs1_data (rf_rs1_data),
        .rf_rs2_data (rf_rs2_data),
        .dec         (dec)
    );

    rv_execute #(
        .BYPASS_DEPTH (BYPASS_DEPTH)
    ) execute_i (
        .clk            (clk),
        .rst            (rst),
        .advance        (advance),
        .dec            (dec),
        .exe            (exe),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .redirect_ack   (redirect_ack)
    );

    rv_result result_i (
        .clk          (clk),
        .rst          (rst),
        .advance      (advance),
        .exe          (exe),
        .rf_rs1       (rf_rs1),
        .rf_rs2       (rf_rs2),
        .rf_rs1_data  (rf_rs1_data),
        .rf_rs2_data  (rf_rs2_data),
        .retire_valid (retire_valid),
        .retire       (retire)
    );

endmodule

// File: source/rv_result.sv
`timescale 1ns/100ps

module rv_result import rv_exec_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      advance,
    input  executed_t exe,
    input  reg_addr_t rf_rs1,
    input  reg_addr_t rf_rs2,
    output xlen_t     rf_rs1_data,
    output xlen_t     rf_rs2_data,
    output logic      retire_valid,
    output retire_t   retire
);

    xlen_t regs [1:31]; // x0 is not stored.
    logic  rf_we;

    assign rf_we = advance && exe.valid && exe.writes_rd && (exe.rd != '0);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (rf_we) begin
            regs[exe.rd] <= exe.wdata;
        end
    end

    assign rf_rs1_data = (rf_rs1 == '0) ? '0 : regs[rf_rs1];
    assign rf_rs2_data = (rf_rs2 == '0) ? '0 : regs[rf_rs2];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            retire_valid <= 1'b0;
            retire       <= '0;
        end else if (advance) begin
            retire_valid <= exe.valid;
            if (exe.valid) begin
                retire.pc      <= exe.pc;
                retire.rd      <= exe.rd;
                retire.wdata   <= exe.wdata;
                retire.we      <= exe.writes_rd && (exe.rd != '0);
                retire.illegal <= exe.illegal;
            end
        end
    end

    // an illegal record never reaches the write port.
    assert property (@(posedge clk) disable iff (rst)
        exe.valid && exe.illegal |-> !exe.writes_rd);

endmodule

// File: source/rv_execute.sv
`timescale 1ns/100ps

module rv_execute import rv_exec_pkg::*; #(
    parameter int BYPASS_DEPTH = 4
) (
    input  logic      clk,
    input  logic      rst,
    input  logic      advance,
    input  decoded_t  dec,
    output executed_t exe,
    output logic      redirect_valid,
    output xlen_t     redirect_pc,
    input  logic      redirect_ack
);

    reg_addr_t hist_rd   [BYPASS_DEPTH];
    xlen_t     hist_data [BYPASS_DEPTH];
    xlen_t     fwd_rs1;
    xlen_t     fwd_rs2;
    xlen_t     src1;
    xlen_t     src2;
    xlen_t     alu_result;
    logic      taken;
    xlen_t     pc_plus4;
    xlen_t     target;
    xlen_t     wdata;
    logic      jumps;
    logic      live;
    logic      take_redirect;
    logic      ack_seen;

    // index 0 is newest, so scan oldest first and let newer hits override.
    always_comb begin
        fwd_rs1 = dec.rs1_data;
        fwd_rs2 = dec.rs2_data;
        for (int i = BYPASS_DEPTH - 1; i >= 0; i--) begin
            if ((hist_rd[i] == dec.rs1) && (dec.rs1 != '0)) fwd_rs1 = hist_data[i];
            if ((hist_rd[i] == dec.rs2) && (dec.rs2 != '0)) fwd_rs2 = hist_data[i];
        end
    end

    assign src1 = dec.src1_is_pc  ? dec.pc  : fwd_rs1;
    assign src2 = dec.src2_is_imm ? dec.imm : fwd_rs2;

    rv_alu alu_i (
        .alu_op  (dec.alu_op),
        .src1    (src1),
        .src2    (src2),
        .cmp_a   (fwd_rs1),
        .cmp_b   (fwd_rs2),
        .br_cond (dec.br_cond),
        .result  (alu_result),
        .taken   (taken)
    );

    assign pc_plus4 = dec.pc + 32'd4;
    assign target   = dec.is_jalr ? {alu_result[31:1], 1'b0} : alu_result;
    assign wdata    = (dec.is_jal || dec.is_jalr) ? pc_plus4 : alu_result; // link value.
    assign jumps    = dec.is_jal || dec.is_jalr || (dec.is_branch && taken);

    // younger records are squashed while a redirect is pending.
    assign live          = dec.valid && !redirect_valid;
    assign take_redirect = live && jumps && (target != pc_plus4);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            redirect_valid <= 1'b0;
            redirect_pc    <= '0;
            ack_seen       <= 1'b0;
        end else begin
            // an ack during a stall is kept until the next advancing edge.
            if (advance && redirect_valid && (redirect_ack || ack_seen)) begin
                redirect_valid <= 1'b0;
                ack_seen       <= 1'b0;
            end else if (redirect_valid && redirect_ack) begin
                ack_seen <= 1'b1;
            end
            if (advance && take_redirect) begin
                redirect_valid <= 1'b1;
                redirect_pc    <= target;
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            exe <= '0;
        end else if (advance) begin
            exe.valid     <= live;
            exe.pc        <= dec.pc;
            exe.rd        <= dec.rd;
            exe.wdata     <= wdata;
            exe.writes_rd <= dec.writes_rd;
            exe.illegal   <= dec.illegal;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < BYPASS_DEPTH; i++) begin
                hist_rd[i]   <= '0;
                hist_data[i] <= '0;
            end
        end else if (advance && live && dec.writes_rd) begin
            for (int i = BYPASS_DEPTH - 1; i > 0; i--) begin
                hist_rd[i]   <= hist_rd[i-1];
                hist_data[i] <= hist_data[i-1];
            end
            hist_rd[0]   <= dec.rd;
            hist_data[0] <= wdata;
        end
    end

    assert property (@(posedge clk) disable iff (rst)
        redirect_valid && !redirect_ack && !ack_seen |=> redirect_valid);

endmodule

// File: source/rv_decode.sv
`timescale 1ns/100ps

module rv_decode import rv_exec_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      advance,
    input  logic      inst_valid,
    input  xlen_t     inst,
    input  xlen_t     pc,
    output reg_addr_t rf_rs1,
    output reg_addr_t rf_rs2,
    input  xlen_t     rf_rs1_data,
    input  xlen_t     rf_rs2_data,
    output decoded_t  dec
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    xlen_t      imm_i;
    xlen_t      imm_b;
    xlen_t      imm_u;
    xlen_t      imm_j;
    decoded_t   dec_d;

    assign opcode = inst[6:0];
    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];

    assign imm_i = {{20{inst[31]}}, inst[31:20]};
    assign imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    assign imm_u = {inst[31:12], 12'h000};
    assign imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

    assign rf_rs1 = inst[19:15];
    assign rf_rs2 = inst[24:20];

    always_comb begin
        dec_d             = '0;
        dec_d.valid       = inst_valid;
        dec_d.pc          = pc;
        dec_d.imm         = imm_i;
        dec_d.rd          = inst[11:7];
        dec_d.rs1         = rf_rs1;
        dec_d.rs2         = rf_rs2;
        dec_d.rs1_data    = rf_rs1_data;
        dec_d.rs2_data    = rf_rs2_data;
        dec_d.alu_op      = ALU_ADD;
        dec_d.br_cond     = funct3;
        case (opcode)
            OPC_LUI: begin
                dec_d.imm         = imm_u;
                dec_d.alu_op      = ALU_PASS;
                dec_d.src2_is_imm = 1'b1;
                dec_d.writes_rd   = 1'b1;
            end
            OPC_AUIPC: begin
                dec_d.imm         = imm_u;
                dec_d.src1_is_pc  = 1'b1;
                dec_d.src2_is_imm = 1'b1;
                dec_d.writes_rd   = 1'b1;
            end
            OPC_JAL: begin
                dec_d.imm         = imm_j;
                dec_d.src1_is_pc  = 1'b1;
                dec_d.src2_is_imm = 1'b1;
                dec_d.is_jal      = 1'b1;
                dec_d.writes_rd   = 1'b1;
            end
            OPC_JALR: begin
                dec_d.src2_is_imm = 1'b1;
                dec_d.is_jalr     = 1'b1;
                dec_d.writes_rd   = 1'b1;
                dec_d.illegal     = (funct3 != 3'b000);
            end
            OPC_BRANCH: begin
                dec_d.imm         = imm_b; // target on the adder, compare apart.
                dec_d.src1_is_pc  = 1'b1;
                dec_d.src2_is_imm = 1'b1;
                dec_d.is_branch   = 1'b1;
                dec_d.illegal     = (funct3[2:1] == 2'b01);
            end
            OPC_OP_IMM: begin
                dec_d.src2_is_imm = 1'b1;
                dec_d.writes_rd   = 1'b1;
                dec_d.alu_op      = {1'b0, funct3};
                if (funct3 == 3'b001) begin
                    dec_d.illegal = (funct7 != 7'b0000000);
                end else if (funct3 == 3'b101) begin
                    dec_d.alu_op  = {funct7[5], funct3};
                    dec_d.illegal = (funct7 != 7'b0000000) && (funct7 != 7'b0100000);
                end
            end
            OPC_OP: begin
                dec_d.writes_rd = 1'b1;
                dec_d.alu_op    = {funct7[5], funct3};
                if (funct7 == 7'b0100000) begin
                    dec_d.illegal = (funct3 != 3'b000) && (funct3 != 3'b101);
                end else begin
                    dec_d.illegal = (funct7 != 7'b0000000);
                end
            end
            default: dec_d.illegal = 1'b1;
        endcase
        // an illegal op retires quietly.
        if (dec_d.illegal) begin
            dec_d.writes_rd = 1'b0;
            dec_d.is_jal    = 1'b0;
            dec_d.is_jalr   = 1'b0;
            dec_d.is_branch = 1'b0;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            dec <= '0;
        end else if (advance) begin
            dec <= dec_d;
        end
    end

    assert property (@(posedge clk) disable iff (rst)
        inst_valid |-> !$isunknown(inst));

endmodule

// File: source/rv_alu.sv
`timescale 1ns/100ps

module rv_alu import rv_exec_pkg::*; (
    input  alu_op_t  alu_op,
    input  xlen_t    src1,
    input  xlen_t    src2,
    input  xlen_t    cmp_a,
    input  xlen_t    cmp_b,
    input  br_cond_t br_cond,
    output xlen_t    result,
    output logic     taken
);

    logic [4:0] shamt;
    logic       lt_signed;
    logic       lt_unsigned;
    logic       equal;

    assign shamt = src2[4:0];

    always_comb begin
        case (alu_op)
            ALU_ADD:  result = src1 + src2;
            ALU_SUB:  result = src1 - src2;
            ALU_SLL:  result = src1 << shamt;
            ALU_SLT:  result = {31'd0, $signed(src1) < $signed(src2)};
            ALU_SLTU: result = {31'd0, src1 < src2};
            ALU_XOR:  result = src1 ^ src2;
            ALU_SRL:  result = src1 >> shamt;
            ALU_SRA:  result = xlen_t'($signed(src1) >>> shamt);
            ALU_OR:   result = src1 | src2;
            ALU_AND:  result = src1 & src2;
            ALU_PASS: result = src2;
            default:  result = src1 + src2;
        endcase
    end

    // comparator runs on the register operands.
    assign equal       = (cmp_a == cmp_b);
    assign lt_signed   = ($signed(cmp_a) < $signed(cmp_b));
    assign lt_unsigned = (cmp_a < cmp_b);

    always_comb begin
        case (br_cond)
            BR_EQ:   taken = equal;
            BR_NE:   taken = !equal;
            BR_LT:   taken = lt_signed;
            BR_GE:   taken = !lt_signed;
            BR_LTU:  taken = lt_unsigned;
            BR_GEU:  taken = !lt_unsigned;
            default: taken = 1'b0;
        endcase
    end

endmodule

// File: source/rv_exec_pkg.sv
package rv_exec_pkg;

    typedef logic [31:0] xlen_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [3:0]  alu_op_t;
    typedef logic [2:0]  br_cond_t;

    // alu op is {funct7[5], funct3} for the register forms.
    localparam alu_op_t ALU_ADD  = 4'b0000;
    localparam alu_op_t ALU_SLL  = 4'b0001;
    localparam alu_op_t ALU_SLT  = 4'b0010;
    localparam alu_op_t ALU_SLTU = 4'b0011;
    localparam alu_op_t ALU_XOR  = 4'b0100;
    localparam alu_op_t ALU_SRL  = 4'b0101;
    localparam alu_op_t ALU_OR   = 4'b0110;
    localparam alu_op_t ALU_AND  = 4'b0111;
    localparam alu_op_t ALU_SUB  = 4'b1000;
    localparam alu_op_t ALU_SRA  = 4'b1101;
    localparam alu_op_t ALU_PASS = 4'b1111; // operand 2 through, for lui.

    localparam br_cond_t BR_EQ  = 3'b000;
    localparam br_cond_t BR_NE  = 3'b001;
    localparam br_cond_t BR_LT  = 3'b100;
    localparam br_cond_t BR_GE  = 3'b101;
    localparam br_cond_t BR_LTU = 3'b110;
    localparam br_cond_t BR_GEU = 3'b111;

    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;

    typedef struct packed {
        logic      valid;
        xlen_t     pc;
        xlen_t     imm;
        reg_addr_t rd;
        reg_addr_t rs1;
        reg_addr_t rs2;
        xlen_t     rs1_data;
        xlen_t     rs2_data;
        alu_op_t   alu_op;
        logic      src1_is_pc;
        logic      src2_is_imm;
        logic      is_jal;
        logic      is_jalr;
        logic      is_branch;
        br_cond_t  br_cond;
        logic      writes_rd;
        logic      illegal;
    } decoded_t;

    typedef struct packed {
        logic      valid;
        xlen_t     pc;
        reg_addr_t rd;
        xlen_t     wdata;
        logic      writes_rd;
        logic      illegal;
    } executed_t;

    typedef struct packed {
        xlen_t     pc;
        reg_addr_t rd;
        xlen_t     wdata;
        logic      we;
        logic      illegal;
    } retire_t;

endpackage
